//--- verilog/rv_decode_pkg.sv
package rv_decode_pkg;

  // ==========================================================
  // Widths and fixed encodings
  // ==========================================================
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // ADDI x0, x0, 0
  localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

  // RV32I base opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // ==========================================================
  // Operation encodings
  // ==========================================================
  typedef enum logic [5:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
    ADDI, ANDI, ORI, XORI, SLTI, SLTIU, SLLI, SRLI, SRAI,
    LUI, AUIPC, JAL, JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    LB, LH, LW, LBU, LHU,
    SB, SH, SW
  } instr_op_e;

  // BR_JUMP covers both JAL and JALR
  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
  } branch_op_e;

  typedef enum logic [1:0] {
    ST_NONE, ST_BYTE, ST_HALF, ST_WORD
  } store_op_e;

  // ==========================================================
  // Instruction word, one view per format
  // ==========================================================
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  // ==========================================================
  // Stage interfaces
  // ==========================================================
  typedef struct packed {
    logic stall;
    logic flush;
  } pipe_ctrl_t;

  typedef struct packed {
    instr_u            instruction;
    logic [XLEN-1:0]   program_counter;
  } fetch_to_id_t;

  typedef struct packed {
    logic                  write_enable;
    logic [REG_ADDR_W-1:0] dest_reg;
    logic [XLEN-1:0]       write_data;
  } wb_write_t;

  typedef struct packed {
    instr_op_e  instr_op;
    branch_op_e branch_op;
    store_op_e  store_op;
    logic       is_load;
    logic       is_load_byte;
    logic       is_load_halfword;
    logic       is_load_unsigned;
    logic       is_jal;
    logic       is_jalr;
    logic       is_illegal;
  } decode_ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] jal_target;
  } imm_set_t;

  typedef struct packed {
    instr_u          instruction;
    logic [XLEN-1:0] program_counter;
    decode_ctrl_t    dec;
    imm_set_t        imm;
    logic [XLEN-1:0] source_reg_1_data;
    logic [XLEN-1:0] source_reg_2_data;
  } id_to_ex_t;

  // Control fields of a bubble
  localparam decode_ctrl_t NOP_DECODE = '{
    instr_op:         ADDI,
    branch_op:        BR_NONE,
    store_op:         ST_NONE,
    is_load:          1'b0,
    is_load_byte:     1'b0,
    is_load_halfword: 1'b0,
    is_load_unsigned: 1'b0,
    is_jal:           1'b0,
    is_jalr:          1'b0,
    is_illegal:       1'b0
  };

endpackage : rv_decode_pkg

//--- verilog/instr_decoder.sv
module instr_decoder (
  input  rv_decode_pkg::instr_u       i_instr,
  output rv_decode_pkg::decode_ctrl_t o_ctrl
);

  // Fields shared by every format sit at the same bits
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = i_instr.r_fmt.opcode;
  assign funct3 = i_instr.r_fmt.funct3;
  assign funct7 = i_instr.r_fmt.funct7;

  always_comb begin
    // Bubble values unless a legal encoding overrides them
    o_ctrl = rv_decode_pkg::NOP_DECODE;

    case (opcode)
      // ==========================================================
      // Register-register ALU
      // ==========================================================
      rv_decode_pkg::OPC_OP: begin
        if (funct7 == 7'h00) begin
          case (funct3)
            3'b000: o_ctrl.instr_op = rv_decode_pkg::ADD;
            3'b001: o_ctrl.instr_op = rv_decode_pkg::SLL;
            3'b010: o_ctrl.instr_op = rv_decode_pkg::SLT;
            3'b011: o_ctrl.instr_op = rv_decode_pkg::SLTU;
            3'b100: o_ctrl.instr_op = rv_decode_pkg::XOR;
            3'b101: o_ctrl.instr_op = rv_decode_pkg::SRL;
            3'b110: o_ctrl.instr_op = rv_decode_pkg::OR;
            default: o_ctrl.instr_op = rv_decode_pkg::AND;
          endcase
        end else if (funct7 == 7'h20 && funct3 == 3'b000) begin
          o_ctrl.instr_op = rv_decode_pkg::SUB;
        end else if (funct7 == 7'h20 && funct3 == 3'b101) begin
          o_ctrl.instr_op = rv_decode_pkg::SRA;
        end else begin
          o_ctrl.is_illegal = 1'b1;
        end
      end

      // ==========================================================
      // Register-immediate ALU
      // ==========================================================
      rv_decode_pkg::OPC_OP_IMM: begin
        case (funct3)
          3'b000: o_ctrl.instr_op = rv_decode_pkg::ADDI;
          3'b010: o_ctrl.instr_op = rv_decode_pkg::SLTI;
          3'b011: o_ctrl.instr_op = rv_decode_pkg::SLTIU;
          3'b100: o_ctrl.instr_op = rv_decode_pkg::XORI;
          3'b110: o_ctrl.instr_op = rv_decode_pkg::ORI;
          3'b111: o_ctrl.instr_op = rv_decode_pkg::ANDI;
          // Shift amount in imm[4:0], upper bits act as funct7
          3'b001: begin
            if (funct7 == 7'h00) o_ctrl.instr_op = rv_decode_pkg::SLLI;
            else o_ctrl.is_illegal = 1'b1;
          end
          default: begin
            if (funct7 == 7'h00) o_ctrl.instr_op = rv_decode_pkg::SRLI;
            else if (funct7 == 7'h20) o_ctrl.instr_op = rv_decode_pkg::SRAI;
            else o_ctrl.is_illegal = 1'b1;
          end
        endcase
      end

      rv_decode_pkg::OPC_LUI:   o_ctrl.instr_op = rv_decode_pkg::LUI;
      rv_decode_pkg::OPC_AUIPC: o_ctrl.instr_op = rv_decode_pkg::AUIPC;

      // ==========================================================
      // Control transfer
      // ==========================================================
      rv_decode_pkg::OPC_JAL: begin
        o_ctrl.instr_op  = rv_decode_pkg::JAL;
        o_ctrl.branch_op = rv_decode_pkg::BR_JUMP;
        o_ctrl.is_jal    = 1'b1;
      end

      rv_decode_pkg::OPC_JALR: begin
        o_ctrl.instr_op  = rv_decode_pkg::JALR;
        o_ctrl.branch_op = rv_decode_pkg::BR_JUMP;
        o_ctrl.is_jalr   = 1'b1;
      end

      rv_decode_pkg::OPC_BRANCH: begin
        case (funct3)
          3'b000: begin
            o_ctrl.instr_op  = rv_decode_pkg::BEQ;
            o_ctrl.branch_op = rv_decode_pkg::BR_EQ;
          end
          3'b001: begin
            o_ctrl.instr_op  = rv_decode_pkg::BNE;
            o_ctrl.branch_op = rv_decode_pkg::BR_NE;
          end
          3'b100: begin
            o_ctrl.instr_op  = rv_decode_pkg::BLT;
            o_ctrl.branch_op = rv_decode_pkg::BR_LT;
          end
          3'b101: begin
            o_ctrl.instr_op  = rv_decode_pkg::BGE;
            o_ctrl.branch_op = rv_decode_pkg::BR_GE;
          end
          3'b110: begin
            o_ctrl.instr_op  = rv_decode_pkg::BLTU;
            o_ctrl.branch_op = rv_decode_pkg::BR_LTU;
          end
          3'b111: begin
            o_ctrl.instr_op  = rv_decode_pkg::BGEU;
            o_ctrl.branch_op = rv_decode_pkg::BR_GEU;
          end
          // funct3 2 and 3 are reserved
          default: o_ctrl.is_illegal = 1'b1;
        endcase
      end

      // ==========================================================
      // Memory access
      // ==========================================================
      rv_decode_pkg::OPC_LOAD: begin
        case (funct3)
          3'b000: o_ctrl.instr_op = rv_decode_pkg::LB;
          3'b001: o_ctrl.instr_op = rv_decode_pkg::LH;
          3'b010: o_ctrl.instr_op = rv_decode_pkg::LW;
          3'b100: o_ctrl.instr_op = rv_decode_pkg::LBU;
          3'b101: o_ctrl.instr_op = rv_decode_pkg::LHU;
          default: o_ctrl.is_illegal = 1'b1;
        endcase
        // Size and sign come straight from funct3
        o_ctrl.is_load          = !o_ctrl.is_illegal;
        o_ctrl.is_load_byte     = !o_ctrl.is_illegal && funct3[1:0] == 2'b00;
        o_ctrl.is_load_halfword = !o_ctrl.is_illegal && funct3[1:0] == 2'b01;
        o_ctrl.is_load_unsigned = !o_ctrl.is_illegal && funct3[2];
      end

      rv_decode_pkg::OPC_STORE: begin
        case (funct3)
          3'b000: begin
            o_ctrl.instr_op = rv_decode_pkg::SB;
            o_ctrl.store_op = rv_decode_pkg::ST_BYTE;
          end
          3'b001: begin
            o_ctrl.instr_op = rv_decode_pkg::SH;
            o_ctrl.store_op = rv_decode_pkg::ST_HALF;
          end
          3'b010: begin
            o_ctrl.instr_op = rv_decode_pkg::SW;
            o_ctrl.store_op = rv_decode_pkg::ST_WORD;
          end
          default: o_ctrl.is_illegal = 1'b1;
        endcase
      end

      // MISC-MEM, SYSTEM and anything unknown
      default: o_ctrl.is_illegal = 1'b1;
    endcase
  end

endmodule : instr_decoder

//--- verilog/imm_target_gen.sv
module imm_target_gen (
  input  rv_decode_pkg::instr_u               i_instr,
  input  logic [rv_decode_pkg::XLEN-1:0]      i_pc,
  output rv_decode_pkg::imm_set_t             o_imm
);

  // Sign bit of every format is instruction bit 31
  logic sign;

  assign sign = i_instr.i_fmt.imm_11_0[11];

  always_comb begin
    // ==========================================================
    // Immediates
    // ==========================================================
    // I type, loads, JALR and ALU immediates
    o_imm.imm_i = {{(rv_decode_pkg::XLEN-12){sign}}, i_instr.i_fmt.imm_11_0};

    // S type, split around rs1/rs2
    o_imm.imm_s = {{(rv_decode_pkg::XLEN-12){sign}},
                   i_instr.s_fmt.imm_11_5,
                   i_instr.s_fmt.imm_4_0};

    // B type, halfword aligned
    o_imm.imm_b = {{(rv_decode_pkg::XLEN-12){i_instr.b_fmt.imm_12}},
                   i_instr.b_fmt.imm_11,
                   i_instr.b_fmt.imm_10_5,
                   i_instr.b_fmt.imm_4_1,
                   1'b0};

    // U type sits in the upper 20 bits
    o_imm.imm_u = {i_instr.u_fmt.imm_31_12, 12'b0};

    // J type, halfword aligned
    o_imm.imm_j = {{(rv_decode_pkg::XLEN-20){i_instr.j_fmt.imm_20}},
                   i_instr.j_fmt.imm_19_12,
                   i_instr.j_fmt.imm_11,
                   i_instr.j_fmt.imm_10_1,
                   1'b0};

    // ==========================================================
    // PC-relative targets
    // ==========================================================
    // Computed for every word, EX picks what it needs
    o_imm.branch_target = i_pc + o_imm.imm_b;
    o_imm.jal_target    = i_pc + o_imm.imm_j;
  end

endmodule : imm_target_gen

//--- verilog/int_regfile.sv
module int_regfile (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0]  i_rs1,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0]  i_rs2,
  input  rv_decode_pkg::wb_write_t              i_wb,
  output logic [rv_decode_pkg::XLEN-1:0]        o_rs1_data,
  output logic [rv_decode_pkg::XLEN-1:0]        o_rs2_data
);

  // x0 has no storage
  logic [rv_decode_pkg::XLEN-1:0] regs [1:rv_decode_pkg::NUM_REGS-1];

  // Write-back lands this edge, drop writes to x0
  logic wb_active;

  assign wb_active = i_wb.write_enable && (i_wb.dest_reg != '0);

  // One read port, with the same-cycle bypass
  function automatic logic [rv_decode_pkg::XLEN-1:0] read_port(
    input logic [rv_decode_pkg::REG_ADDR_W-1:0] idx
  );
    if (idx == '0) begin
      return '0;
    end else if (wb_active && i_wb.dest_reg == idx) begin
      // Array still holds the old value until the edge
      return i_wb.write_data;
    end else begin
      return regs[idx];
    end
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int r = 1; r < rv_decode_pkg::NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (wb_active) begin
      regs[i_wb.dest_reg] <= i_wb.write_data;
    end
  end

  always_comb begin
    o_rs1_data = read_port(i_rs1);
    o_rs2_data = read_port(i_rs2);
  end

endmodule : int_regfile

//--- verilog/id_ex_register.sv
module id_ex_register (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  rv_decode_pkg::pipe_ctrl_t         i_ctrl,
  input  rv_decode_pkg::instr_u             i_instr,
  input  logic [rv_decode_pkg::XLEN-1:0]    i_pc,
  input  rv_decode_pkg::decode_ctrl_t       i_dec,
  input  rv_decode_pkg::imm_set_t           i_imm,
  input  logic [rv_decode_pkg::XLEN-1:0]    i_rs1_data,
  input  logic [rv_decode_pkg::XLEN-1:0]    i_rs2_data,
  output rv_decode_pkg::id_to_ex_t          o_to_ex
);

  // Advance when EX is not holding us
  logic advance;

  assign advance = !i_ctrl.stall;

  // ==========================================================
  // Control fields
  // ==========================================================
  // Reset, then stall, then flush
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_to_ex.instruction <= rv_decode_pkg::NOP_WORD;
      o_to_ex.dec         <= rv_decode_pkg::NOP_DECODE;
    end else if (advance) begin
      if (i_ctrl.flush) begin
        // Squash into a bubble
        o_to_ex.instruction <= rv_decode_pkg::NOP_WORD;
        o_to_ex.dec         <= rv_decode_pkg::NOP_DECODE;
      end else begin
        o_to_ex.instruction <= i_instr;
        o_to_ex.dec         <= i_dec;
      end
    end
  end

  // ==========================================================
  // Datapath fields
  // ==========================================================
  // Only stall holds these, a flushed slot still carries them
  always_ff @(posedge i_clk) begin
    if (advance) begin
      o_to_ex.program_counter   <= i_pc;
      o_to_ex.imm               <= i_imm;
      o_to_ex.source_reg_1_data <= i_rs1_data;
      o_to_ex.source_reg_2_data <= i_rs2_data;
    end
  end

endmodule : id_ex_register

//--- verilog/id_stage.sv
module id_stage (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  rv_decode_pkg::pipe_ctrl_t     i_ctrl,
  input  rv_decode_pkg::fetch_to_id_t   i_fetch,
  input  rv_decode_pkg::wb_write_t      i_wb,
  output rv_decode_pkg::id_to_ex_t      o_to_ex
);

  // Decode results feeding the ID/EX register
  rv_decode_pkg::decode_ctrl_t    dec;
  rv_decode_pkg::imm_set_t        imm;
  logic [rv_decode_pkg::XLEN-1:0] rs1_data;
  logic [rv_decode_pkg::XLEN-1:0] rs2_data;

  // Opcode, funct and register fields
  instr_decoder u_decoder (
    .i_instr (i_fetch.instruction),
    .o_ctrl  (dec)
  );

  // Immediates and PC-relative targets
  imm_target_gen u_imm (
    .i_instr (i_fetch.instruction),
    .i_pc    (i_fetch.program_counter),
    .o_imm   (imm)
  );

  // Source operands, bypassed from write-back
  int_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1      (i_fetch.instruction.r_fmt.rs1),
    .i_rs2      (i_fetch.instruction.r_fmt.rs2),
    .i_wb       (i_wb),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  id_ex_register u_id_ex (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_ctrl     (i_ctrl),
    .i_instr    (i_fetch.instruction),
    .i_pc       (i_fetch.program_counter),
    .i_dec      (dec),
    .i_imm      (imm),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_to_ex    (o_to_ex)
  );

endmodule : id_stage

//--- tb/tb_id_tasks.svh
`ifndef TB_ID_TASKS_SVH
`define TB_ID_TASKS_SVH

// ============================================================
// Compare and bookkeeping
// ============================================================
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  check_count++;
  if (actual !== expected) begin
    $display("mismatch %s: expected %h, got %h", name, expected, actual);
    error_count++;
    test_errors++;
  end
endtask

// One line per finished test
task automatic end_test(input string name);
  test_count++;
  if (test_errors == 0) begin
    $display("test %s passed", name);
  end else begin
    $display("test %s: %0d errors", name, test_errors);
  end
  test_errors = 0;
endtask

// Flags packed as load, byte, half, unsigned, jal, jalr, illegal
task automatic check_decode(input rv_decode_pkg::instr_op_e op,
                            input rv_decode_pkg::branch_op_e br,
                            input rv_decode_pkg::store_op_e st,
                            input logic [6:0] flags);
  check_value("instr_op", 32'(op), 32'(to_ex.dec.instr_op));
  check_value("branch_op", 32'(br), 32'(to_ex.dec.branch_op));
  check_value("store_op", 32'(st), 32'(to_ex.dec.store_op));
  check_value("flags", 32'(flags),
              32'({to_ex.dec.is_load, to_ex.dec.is_load_byte, to_ex.dec.is_load_halfword,
                   to_ex.dec.is_load_unsigned, to_ex.dec.is_jal, to_ex.dec.is_jalr,
                   to_ex.dec.is_illegal}));
endtask

// ============================================================
// Instruction encoders, straight from the RV32I formats
// ============================================================
function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, rv_decode_pkg::OPC_OP};
endfunction

function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type_word(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_decode_pkg::OPC_STORE};
endfunction

// Offset bit 0 is implied zero
function automatic logic [31:0] b_type_word(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_decode_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd,
                                            input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_type_word(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_decode_pkg::OPC_JAL};
endfunction

// ============================================================
// Drive helpers
// ============================================================
// Wait until the given PC shows up at the ID/EX output
task automatic wait_capture(input logic [31:0] pc);
  int   cycles;
  logic seen;
  cycles = 0;
  seen   = 1'b0;
  while (!seen && cycles < wait_limit) begin
    @(negedge clk);
    if (to_ex.program_counter === pc) begin
      seen = 1'b1;
    end else begin
      cycles++;
    end
  end
  if (!seen) begin
    $display("timeout: program counter %h never reached the ID/EX output", pc);
    error_count++;
    test_errors++;
  end else begin
    // One edge from input to output
    check_value("latency", 1, cycles);
  end
endtask

task automatic issue(input logic [31:0] word, input logic [31:0] pc);
  @(posedge clk);
  fetch.instruction     <= word;
  fetch.program_counter <= pc;
  wait_capture(pc);
endtask

// Fresh PC per word so every capture is visible
task automatic issue_next(input logic [31:0] word);
  logic [31:0] pc;
  pc      = next_pc;
  next_pc = next_pc + 32'd4;
  issue(word, pc);
endtask

// Single write-back pulse
task automatic write_reg(input logic [4:0] idx, input logic [31:0] data);
  @(posedge clk);
  wb <= '{write_enable: 1'b1, dest_reg: idx, write_data: data};
  @(posedge clk);
  wb <= '0;
endtask

// ============================================================
// Directed tests
// ============================================================
task automatic test_reset_state();
  @(negedge clk);
  check_value("instruction", rv_decode_pkg::NOP_WORD, to_ex.instruction);
  check_decode(rv_decode_pkg::ADDI, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE, 7'b0);
  end_test("reset_state");
endtask

task automatic test_alu_mem_decode();
  logic [11:0] imm;
  issue_next(r_type_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
  check_decode(rv_decode_pkg::ADD, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE, 7'b0);
  issue_next(r_type_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
  check_decode(rv_decode_pkg::SUB, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE, 7'b0);
  // Shift amount 7 with the arithmetic funct7
  issue_next(i_type_word({7'h20, 5'd7}, 5'd1, 3'b101, 5'd4, rv_decode_pkg::OPC_OP_IMM));
  check_decode(rv_decode_pkg::SRAI, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE, 7'b0);
  check_value("imm_i", 32'($signed({7'h20, 5'd7})), to_ex.imm.imm_i);
  issue_next(i_type_word(12'hf00, 5'd2, 3'b110, 5'd6, rv_decode_pkg::OPC_OP_IMM));
  check_decode(rv_decode_pkg::ORI, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE, 7'b0);
  check_value("imm_i", 32'($signed(12'hf00)), to_ex.imm.imm_i);
  issue_next(u_type_word(20'habcde, 5'd7, rv_decode_pkg::OPC_LUI));
  check_decode(rv_decode_pkg::LUI, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE, 7'b0);
  check_value("imm_u", {20'habcde, 12'h000}, to_ex.imm.imm_u);
  issue_next(u_type_word(20'h80001, 5'd8, rv_decode_pkg::OPC_AUIPC));
  check_decode(rv_decode_pkg::AUIPC, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE, 7'b0);
  check_value("imm_u", {20'h80001, 12'h000}, to_ex.imm.imm_u);
  // Loads with size and sign flags
  issue_next(i_type_word(12'hffc, 5'd1, 3'b000, 5'd10, rv_decode_pkg::OPC_LOAD));
  check_decode(rv_decode_pkg::LB, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE, 7'b1100000);
  check_value("imm_i", 32'($signed(12'hffc)), to_ex.imm.imm_i);
  issue_next(i_type_word(12'h7ff, 5'd1, 3'b101, 5'd11, rv_decode_pkg::OPC_LOAD));
  check_decode(rv_decode_pkg::LHU, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE, 7'b1011000);
  check_value("imm_i", 32'($signed(12'h7ff)), to_ex.imm.imm_i);
  issue_next(i_type_word(12'h010, 5'd1, 3'b010, 5'd12, rv_decode_pkg::OPC_LOAD));
  check_decode(rv_decode_pkg::LW, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE, 7'b1000000);
  // Stores
  issue_next(s_type_word(12'hfff, 5'd2, 5'd1, 3'b000));
  check_decode(rv_decode_pkg::SB, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_BYTE, 7'b0);
  check_value("imm_s", 32'($signed(12'hfff)), to_ex.imm.imm_s);
  issue_next(s_type_word(12'h823, 5'd3, 5'd1, 3'b010));
  check_decode(rv_decode_pkg::SW, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_WORD, 7'b0);
  check_value("imm_s", 32'($signed(12'h823)), to_ex.imm.imm_s);
  // Random ADDI words
  for (int n = 0; n < 20; n++) begin
    imm = 12'($urandom);
    issue_next(i_type_word(imm, 5'($urandom), 3'b000, 5'($urandom),
                           rv_decode_pkg::OPC_OP_IMM));
    check_value("imm_i", 32'($signed(imm)), to_ex.imm.imm_i);
    check_value("is_illegal", 32'd0, 32'(to_ex.dec.is_illegal));
  end
  end_test("alu_mem_decode");
endtask

task automatic test_control_transfer();
  // Forward branch
  issue(b_type_word(13'h0100, 5'd2, 5'd1, 3'b000), 32'h0000_4000);
  check_decode(rv_decode_pkg::BEQ, rv_decode_pkg::BR_EQ, rv_decode_pkg::ST_NONE, 7'b0);
  check_value("imm_b", 32'($signed(13'h0100)), to_ex.imm.imm_b);
  check_value("branch_target", 32'h0000_4000 + 32'($signed(13'h0100)),
              to_ex.imm.branch_target);
  // Backward branch
  issue(b_type_word(13'h1fe0, 5'd4, 5'd3, 3'b111), 32'h0000_5000);
  check_decode(rv_decode_pkg::BGEU, rv_decode_pkg::BR_GEU, rv_decode_pkg::ST_NONE, 7'b0);
  check_value("branch_target", 32'h0000_5000 + 32'($signed(13'h1fe0)),
              to_ex.imm.branch_target);
  issue(j_type_word(21'h012344, 5'd1), 32'h0000_8000);
  check_decode(rv_decode_pkg::JAL, rv_decode_pkg::BR_JUMP, rv_decode_pkg::ST_NONE, 7'b0000100);
  check_value("imm_j", 32'($signed(21'h012344)), to_ex.imm.imm_j);
  check_value("jal_target", 32'h0000_8000 + 32'($signed(21'h012344)), to_ex.imm.jal_target);
  issue(j_type_word(21'h1ff800, 5'd1), 32'h0000_9000);
  check_value("jal_target", 32'h0000_9000 + 32'($signed(21'h1ff800)), to_ex.imm.jal_target);
  // Register-relative jump
  issue(i_type_word(12'hff0, 5'd1, 3'b000, 5'd1, rv_decode_pkg::OPC_JALR), 32'h0000_a000);
  check_decode(rv_decode_pkg::JALR, rv_decode_pkg::BR_JUMP, rv_decode_pkg::ST_NONE, 7'b0000010);
  check_value("imm_i", 32'($signed(12'hff0)), to_ex.imm.imm_i);
  end_test("control_transfer");
endtask

task automatic test_operands_bypass();
  logic [31:0] pc;
  write_reg(5'd5, 32'h1234_5678);
  write_reg(5'd9, 32'hcafe_f00d);
  issue_next(r_type_word(7'h00, 5'd9, 5'd5, 3'b000, 5'd1));
  check_value("source_reg_1_data", 32'h1234_5678, to_ex.source_reg_1_data);
  check_value("source_reg_2_data", 32'hcafe_f00d, to_ex.source_reg_2_data);
  // Rewrite x5 on the same edge that reads it
  pc      = next_pc;
  next_pc = next_pc + 32'd4;
  @(posedge clk);
  fetch.instruction     <= r_type_word(7'h00, 5'd9, 5'd5, 3'b000, 5'd1);
  fetch.program_counter <= pc;
  wb                    <= '{write_enable: 1'b1, dest_reg: 5'd5, write_data: 32'h0bad_beef};
  wait_capture(pc);
  check_value("source_reg_1_data", 32'h0bad_beef, to_ex.source_reg_1_data);
  check_value("source_reg_2_data", 32'hcafe_f00d, to_ex.source_reg_2_data);
  @(posedge clk);
  wb <= '0;
  // Value stays in the array
  issue_next(r_type_word(7'h00, 5'd9, 5'd5, 3'b000, 5'd1));
  check_value("source_reg_1_data", 32'h0bad_beef, to_ex.source_reg_1_data);
  // x0 ignores writes
  write_reg(5'd0, 32'hffff_ffff);
  issue_next(r_type_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd1));
  check_value("source_reg_1_data", 32'h0, to_ex.source_reg_1_data);
  check_value("source_reg_2_data", 32'h0, to_ex.source_reg_2_data);
  end_test("operands_bypass");
endtask

task automatic test_stall_flush();
  logic [31:0] held_pc;
  logic [31:0] held_word;
  logic [31:0] pc;
  // ADDI x3, x5, 0x55 with x5 still holding the bypassed value
  held_pc   = next_pc;
  held_word = i_type_word(12'h055, 5'd5, 3'b000, 5'd3, rv_decode_pkg::OPC_OP_IMM);
  issue_next(held_word);
  // Hold while the inputs keep moving
  for (int n = 0; n < 5; n++) begin
    @(posedge clk);
    ctrl.stall            <= 1'b1;
    fetch.instruction     <= $urandom;
    fetch.program_counter <= next_pc;
    next_pc = next_pc + 32'd4;
    @(negedge clk);
    check_value("program_counter", held_pc, to_ex.program_counter);
    check_value("instruction", held_word, to_ex.instruction);
    check_value("imm_i", 32'h0000_0055, to_ex.imm.imm_i);
    check_value("source_reg_1_data", 32'h0bad_beef, to_ex.source_reg_1_data);
    check_decode(rv_decode_pkg::ADDI, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE, 7'b0);
  end
  // Flush a store into a bubble
  pc      = next_pc;
  next_pc = next_pc + 32'd4;
  @(posedge clk);
  ctrl                  <= '{stall: 1'b0, flush: 1'b1};
  fetch.instruction     <= s_type_word(12'h004, 5'd9, 5'd5, 3'b000);
  fetch.program_counter <= pc;
  wait_capture(pc);
  check_value("instruction", rv_decode_pkg::NOP_WORD, to_ex.instruction);
  check_decode(rv_decode_pkg::ADDI, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE, 7'b0);
  check_value("program_counter", pc, to_ex.program_counter);
  check_value("source_reg_1_data", 32'h0bad_beef, to_ex.source_reg_1_data);
  @(posedge clk);
  ctrl <= '0;
  end_test("stall_flush");
endtask

task automatic test_illegal();
  logic [31:0] words [4];
  words[0] = i_type_word(12'h000, 5'd1, 3'b000, 5'd1, 7'b0001011);
  words[1] = 32'h0000_0073;
  words[2] = b_type_word(13'h0010, 5'd2, 5'd1, 3'b010);
  words[3] = r_type_word(7'h01, 5'd2, 5'd1, 3'b000, 5'd3);
  for (int n = 0; n < 4; n++) begin
    issue_next(words[n]);
    check_decode(rv_decode_pkg::ADDI, rv_decode_pkg::BR_NONE, rv_decode_pkg::ST_NONE,
                 7'b0000001);
  end
  end_test("illegal");
endtask

`endif

//--- tb/tb_id_stage.sv
module tb_id_stage;

  // DUT connections
  logic                        clk;
  logic                        rst;
  rv_decode_pkg::pipe_ctrl_t   ctrl;
  rv_decode_pkg::fetch_to_id_t fetch;
  rv_decode_pkg::wb_write_t    wb;
  rv_decode_pkg::id_to_ex_t    to_ex;

  // Run statistics
  int error_count;
  int test_errors;
  int check_count;
  int test_count;

  // Edges allowed before a capture counts as lost
  int wait_limit;

  // Next free PC for issued words
  logic [31:0] next_pc;

  id_stage dut (
    .i_clk   (clk),
    .i_rst   (rst),
    .i_ctrl  (ctrl),
    .i_fetch (fetch),
    .i_wb    (wb),
    .o_to_ex (to_ex)
  );

  `include "tb_id_tasks.svh"

  // ============================================================
  // Clock
  // ============================================================
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin
    void'($urandom(32'h0090_a662));
    error_count = 0;
    test_errors = 0;
    check_count = 0;
    test_count  = 0;
    wait_limit  = 20;
    next_pc     = 32'h0000_1000;

    // Idle inputs, reset held over two edges
    rst                   <= 1'b1;
    ctrl                  <= '0;
    fetch.instruction     <= rv_decode_pkg::NOP_WORD;
    fetch.program_counter <= '0;
    wb                    <= '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    test_reset_state();
    test_alu_mem_decode();
    test_control_transfer();
    test_operands_bypass();
    test_stall_flush();
    test_illegal();

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : tb_id_stage

//--- sources.f
+incdir+tb
verilog/rv_decode_pkg.sv
verilog/instr_decoder.sv
verilog/imm_target_gen.sv
verilog/int_regfile.sv
verilog/id_ex_register.sv
verilog/id_stage.sv
tb/tb_id_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing -f sources.f --top-module tb_id_stage \
    -Mdir "$build_dir" -o tb_id_stage; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./$build_dir/tb_id_stage" > "$log_file" 2>&1; then
  cat "$log_file"
  echo "Simulation run failed"
  exit 1
fi

cat "$log_file"
if grep -q "Something failed" "$log_file"; then
  exit 1
fi
exit 0
